// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_gfx_tile
RTL_TOP   := gfx_tile_top
FILELIST  := sim.f
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) common/gfx_consts.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN) testbench/gfx_golden.txt
	@out=$$(./$(SIM_BIN) 2>&1); echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== common/gfx_consts.svh ====
//************************************************************
// Tile renderer constants: lanes, tile size, seeds, registers
//************************************************************
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

`define GFX_LANES 4                // Render lanes
`define GFX_ADDR_W 6               // 8x8 tile, y then x

// Memory reset seeds
`define GFX_FB_SEED 24'h3C5A96
`define GFX_TEX_SEED 24'hC3A569

`define GFX_QUEUE_DEPTH 4          // Result queue entries

// APB register map
`define GFX_REG_PIXEL 8'h00
`define GFX_REG_CMD 8'h04
`define GFX_REG_RESULT 8'h08
`define GFX_REG_STATUS 8'h0C

`endif

// ==== common/gfx_pkg.sv ====
//************************************************************
// Pixel, render command and result types
//************************************************************
`include "gfx_consts.svh"

package gfx_pkg;

    localparam int LANE_W = $clog2(`GFX_LANES);

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Channels for blend and shader, raw word for filter and texture copy
    typedef union packed {
        rgb_t        ch;
        logic [23:0] raw;
    } pixel_u;

    typedef enum logic [1:0] {
        MODE_COPY   = 2'd0,
        MODE_BLEND  = 2'd1,
        MODE_SHADER = 2'd2,
        MODE_FILTER = 2'd3
    } render_mode_e;

    typedef struct packed {
        logic                   op_read;   // Texture read when set
        logic [LANE_W-1:0]      lane;
        render_mode_e           mode;
        logic [`GFX_ADDR_W-1:0] addr;
        pixel_u                 pixel;
    } gfx_cmd_t;

    // Exactly one APB data word
    typedef struct packed {
        logic [LANE_W-1:0]      lane;
        logic [`GFX_ADDR_W-1:0] addr;
        pixel_u                 pixel;
    } gfx_result_t;

endpackage

// ==== logic/gfx_tile_top.sv ====
//************************************************************
// Tile renderer top: dispatcher, render lanes, collector
//************************************************************
`timescale 1ns/1ns
`include "gfx_consts.svh"

module gfx_tile_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                  wr_ready;
    logic [`GFX_LANES-1:0] start;
    logic [`GFX_LANES-1:0] lane_busy;
    logic [`GFX_LANES-1:0] done;
    logic [`GFX_LANES-1:0] taken;
    gfx_pkg::gfx_cmd_t     cmd;
    gfx_pkg::gfx_result_t  results [`GFX_LANES];
    logic [31:0]           col_rdata;

    render_dispatch u_dispatch (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .lane_busy (lane_busy),
        .wr_ready  (wr_ready),
        .start     (start),
        .cmd       (cmd)
    );

    for (genvar g = 0; g < `GFX_LANES; g++) begin : g_lane
        render_lane #(
            .lane_id (g)
        ) u_lane (
            .clk    (clk),
            .rst    (rst),
            .start  (start[g]),
            .cmd    (cmd),
            .taken  (taken[g]),
            .busy   (lane_busy[g]),
            .done   (done[g]),
            .result (results[g])
        );
    end

    result_collect u_collect (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .results   (results),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .lane_busy (lane_busy),
        .taken     (taken),
        .prdata    (col_rdata)
    );

    // Reads never stall, only CMD writes do
    assign pready  = wr_ready;
    assign pslverr = 1'b0;
    assign prdata  = (paddr == `GFX_REG_RESULT || paddr == `GFX_REG_STATUS) ? col_rdata : 32'b0;

endmodule

// ==== logic/result_collect.sv ====
//************************************************************
// Lane result holds, priority arbiter, result queue, status
//************************************************************
`timescale 1ns/1ns
`include "gfx_consts.svh"

module result_collect (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`GFX_LANES-1:0] done,
    input  gfx_pkg::gfx_result_t  results [`GFX_LANES],
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [`GFX_LANES-1:0] lane_busy,
    output logic [`GFX_LANES-1:0] taken,
    output logic [31:0]           prdata
);

    localparam int ptr_w = $clog2(`GFX_QUEUE_DEPTH);
    localparam int cnt_w = $clog2(`GFX_QUEUE_DEPTH + 1);

    logic [`GFX_LANES-1:0]      hold_vld;
    gfx_pkg::gfx_result_t       hold_q    [`GFX_LANES];
    gfx_pkg::gfx_result_t       queue_mem [`GFX_QUEUE_DEPTH];
    logic [ptr_w-1:0]           rd_ptr;
    logic [ptr_w-1:0]           wr_ptr;
    logic [cnt_w-1:0]           count;
    logic [gfx_pkg::LANE_W-1:0] grant;
    logic                       any_hold;
    logic                       pop;
    logic                       push;
    logic [7:0]                 status;

    // Lowest lane index wins
    always_comb begin
        grant    = '0;
        any_hold = 1'b0;
        for (int i = `GFX_LANES - 1; i >= 0; i--) begin
            if (hold_vld[i]) begin
                grant    = gfx_pkg::LANE_W'(i);
                any_hold = 1'b1;
            end
        end
    end

    assign pop   = psel && penable && !pwrite && (paddr == `GFX_REG_RESULT) && (count != '0);
    assign push  = any_hold && ((count != cnt_w'(`GFX_QUEUE_DEPTH)) || pop);
    assign taken = push ? (`GFX_LANES'(1) << grant) : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_vld <= '0;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
        end else begin
            for (int i = 0; i < `GFX_LANES; i++) begin
                if (done[i]) begin
                    hold_vld[i] <= 1'b1;
                end else if (taken[i]) begin
                    hold_vld[i] <= 1'b0;
                end
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `GFX_LANES; i++) begin
            if (done[i]) begin
                hold_q[i] <= results[i];
            end
        end
        if (push) begin
            queue_mem[wr_ptr] <= hold_q[grant];
        end
    end

    assign status = {count != '0, count, lane_busy};   // Not empty, count, busy bits

    // Empty queue reads as zero
    assign prdata = (paddr == `GFX_REG_STATUS) ? {24'b0, status} :
                    (count != '0)              ? queue_mem[rd_ptr] : 32'b0;

endmodule

// ==== render/render_dispatch.sv ====
//************************************************************
// APB write decode, pending pixel and lane command launch
//************************************************************
`timescale 1ns/1ns
`include "gfx_consts.svh"

// CMD word: [10] op_read, [9:8] lane, [7:6] mode, [5:0] addr
module render_dispatch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [31:0]           pwdata,
    input  logic [`GFX_LANES-1:0] lane_busy,
    output logic                  wr_ready,
    output logic [`GFX_LANES-1:0] start,
    output gfx_pkg::gfx_cmd_t     cmd
);

    logic [gfx_pkg::LANE_W-1:0] tgt_lane;
    logic                       cmd_hit;
    logic                       pixel_wr;
    logic                       stall;
    logic                       launch;
    gfx_pkg::pixel_u            pend_pix;

    assign tgt_lane = pwdata[8 +: gfx_pkg::LANE_W];
    assign cmd_hit  = psel && pwrite && (paddr == `GFX_REG_CMD);
    assign pixel_wr = psel && penable && pwrite && (paddr == `GFX_REG_PIXEL);

    // Lane still busy, or launched but not yet showing busy
    assign stall    = cmd_hit && (lane_busy[tgt_lane] || start[tgt_lane]);
    assign wr_ready = !stall;
    assign launch   = cmd_hit && penable && !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start <= '0;
        end else if (launch) begin
            start <= `GFX_LANES'(1) << tgt_lane;   // One-cycle pulse
        end else begin
            start <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_wr) begin
            pend_pix.raw <= pwdata[23:0];
        end
        if (launch) begin
            cmd.op_read <= pwdata[10];
            cmd.lane    <= tgt_lane;
            cmd.mode    <= gfx_pkg::render_mode_e'(pwdata[7:6]);
            cmd.addr    <= pwdata[`GFX_ADDR_W-1:0];
            cmd.pixel   <= pend_pix;
        end
    end

endmodule

// ==== render/render_lane.sv ====
//************************************************************
// Render lane: framebuffer, texture memory, render FSM
//************************************************************
`timescale 1ns/1ns
`include "gfx_consts.svh"

module render_lane #(
    parameter int lane_id = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  gfx_pkg::gfx_cmd_t    cmd,
    input  logic                 taken,
    output logic                 busy,
    output logic                 done,
    output gfx_pkg::gfx_result_t result
);

    localparam int depth = 1 << `GFX_ADDR_W;
    localparam logic [gfx_pkg::LANE_W-1:0] lane_tag = gfx_pkg::LANE_W'(lane_id);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_PROCESS,
        S_OUTPUT,
        S_WAIT
    } state_e;

    state_e            state;
    logic [23:0]       fb_mem  [depth];
    logic [23:0]       tex_mem [depth];
    gfx_pkg::gfx_cmd_t cmd_q;
    gfx_pkg::pixel_u   texel_q;
    gfx_pkg::pixel_u   fb_q;         // Framebuffer word before the write
    gfx_pkg::pixel_u   new_pix;
    gfx_pkg::pixel_u   out_q;
    logic [23:0]       diff_ab;
    logic [23:0]       diff_ba;

    // New framebuffer word per render mode
    always_comb begin
        diff_ab = cmd_q.pixel.raw - fb_q.raw;
        diff_ba = fb_q.raw - cmd_q.pixel.raw;
        new_pix = cmd_q.pixel;
        case (cmd_q.mode)
            gfx_pkg::MODE_BLEND: begin
                new_pix.ch.r = (cmd_q.pixel.ch.r >> 1) + (texel_q.ch.r >> 1);
                new_pix.ch.g = (cmd_q.pixel.ch.g >> 1) + (texel_q.ch.g >> 1);
                new_pix.ch.b = (cmd_q.pixel.ch.b >> 1) + (texel_q.ch.b >> 1);
            end
            gfx_pkg::MODE_SHADER: begin
                new_pix.ch.r = ~cmd_q.pixel.ch.r;  // 255 - r
                new_pix.ch.g = ~cmd_q.pixel.ch.g;
                new_pix.ch.b = ~cmd_q.pixel.ch.b;
            end
            gfx_pkg::MODE_FILTER: begin
                new_pix.raw = (cmd_q.pixel.raw > fb_q.raw) ? diff_ab : diff_ba;
            end
            default: new_pix = cmd_q.pixel;       // Copy
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            for (int i = 0; i < depth; i++) begin
                fb_mem[i]  <= `GFX_FB_SEED ^ 24'({lane_tag, `GFX_ADDR_W'(i)});
                tex_mem[i] <= `GFX_TEX_SEED ^ 24'({lane_tag, `GFX_ADDR_W'(i)});
            end
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_PROCESS;
                S_PROCESS: begin
                    if (!cmd_q.op_read) begin
                        fb_mem[cmd_q.addr] <= new_pix.raw;
                    end
                    state <= S_OUTPUT;
                end
                S_OUTPUT: state <= S_WAIT;
                S_WAIT: begin
                    if (taken) begin              // Collector moved result to queue
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            cmd_q <= cmd;
        end
        if (state == S_FETCH) begin
            texel_q.raw <= tex_mem[cmd_q.addr];
            fb_q.raw    <= fb_mem[cmd_q.addr];
        end
        if (state == S_PROCESS) begin
            out_q <= cmd_q.op_read ? texel_q : new_pix;
        end
    end

    assign busy         = (state != S_IDLE);
    assign done         = (state == S_OUTPUT);  // Three cycles after start
    assign result.lane  = lane_tag;
    assign result.addr  = cmd_q.addr;
    assign result.pixel = out_q;

endmodule

// ==== sim.f ====
+incdir+common
common/gfx_pkg.sv
render/render_lane.sv
render/render_dispatch.sv
logic/result_collect.sv
logic/gfx_tile_top.sv
testbench/tb_gfx_tile.sv

// ==== testbench/gfx_golden.txt ====
// Columns op_addr_data_poll: op 1 write or 2 read, APB address, write data or expected
// read data, poll 1 waits on STATUS for a non-empty result queue before the operation
2_0C_00000000_0
2_08_00000000_0
// Texture reads, one per lane
1_04_00000405_0
2_08_05C3A56C_1
1_04_00000512_0
2_08_52C3A53B_1
1_04_0000062A_0
2_08_AAC3A5C3_1
1_04_0000073F_0
2_08_FFC3A596_1
// Copy and shader, then read back by filter with a zero pixel
1_00_00123456_0
1_04_00000009_0
2_08_09123456_1
1_00_0010F080_0
1_04_0000018A_0
2_08_4AEF0F7F_1
1_00_00000000_0
1_04_000000C9_0
2_08_09123456_1
1_04_000001CA_0
2_08_4AEF0F7F_1
// Blend on lane 2, filter both ways on lane 3
1_00_0040A0FF_0
1_04_00000251_0
2_08_9181A2FB_1
1_00_00500000_0
1_04_000003E0_0
2_08_E013A58A_1
1_00_00100000_0
1_04_000003E0_0
2_08_E003A58A_1
// All four lanes back to back
1_00_00A5A5A5_0
1_04_00000001_0
1_04_00000102_0
1_04_00000203_0
1_04_00000304_0
2_00_00000000_0
2_00_00000000_0
2_00_00000000_0
2_0C_000000C0_0
2_08_01A5A5A5_0
2_08_42A5A5A5_0
2_08_83A5A5A5_0
2_08_C4A5A5A5_0
2_0C_00000000_0
// Second CMD to a busy lane stalls
1_00_000000FF_0
1_04_00000130_0
1_00_0000FF00_0
1_04_00000131_0
2_08_700000FF_1
2_08_7100FF00_1
2_08_00000000_0
2_0C_00000000_0

// ==== testbench/tb_gfx_tile.sv ====
//************************************************************
// Tile renderer testbench: golden-file APB replay with checks
//************************************************************
`timescale 1ns/1ns
`include "gfx_consts.svh"

module tb_gfx_tile;

    localparam int max_lines       = 256;
    localparam int cycles_per_line = 40;
    localparam int reset_cycles    = 8;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [47:0] golden [max_lines];  // Op, address, data, poll flag
    int          num_lines   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;     // Zero until the golden file is sized

    gfx_tile_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;            // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display(">>> FAIL");
            $fatal(1, "Simulation timeout");
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %08h, expected %08h", $time, name, actual,
                     expected);
            $display(">>> FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Setup phase, access phase, then wait states until pready
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        rdata = prdata;
        check_value("pslverr", {31'b0, pslverr}, 32'h0);
    endtask

    task automatic wait_result_ready();
        logic [31:0] status;
        status = '0;
        while (!status[7]) begin      // Queue not empty
            apb_transfer(1'b0, `GFX_REG_STATUS, 32'h0, status);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [3:0]  op;
        logic [7:0]  addr;
        logic [31:0] data;
        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < max_lines; i++) begin
            golden[i] = '0;
        end
        $readmemh("testbench/gfx_golden.txt", golden);
        while (num_lines < max_lines && golden[num_lines][47:44] != 4'h0) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            stop_run("The golden file holds no operations");
        end
        cycle_limit = reset_cycles + 2 + cycles_per_line * num_lines;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < num_lines; i++) begin
            op   = golden[i][47:44];
            addr = golden[i][43:36];
            data = golden[i][35:4];
            if (golden[i][3:0] != 4'h0) begin
                wait_result_ready();
            end
            if (op == 4'h1) begin
                apb_transfer(1'b1, addr, data, rdata);
            end else if (op == 4'h2) begin
                apb_transfer(1'b0, addr, 32'h0, rdata);
                check_value($sformatf("prdata at address %02h", addr), rdata, data);
            end else begin
                stop_run($sformatf("Unknown operation %0h on golden line %0d", op, i));
            end
        end

        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        $display(">>> PASS");
        $finish;
    end

endmodule
